/* tests/data_cache_cases.txt */
# test op(0 read, 1 write, 2 reset) addr wdata exp_rdata exp_hit, all but test/op/hit in hex
# memory starts with every word equal to its own word address
1 0 0010 0000 0010 0
1 0 0013 0000 0013 1
1 0 1234 0000 1234 0
1 0 1237 0000 1237 1
2 1 0120 beef beef 0
2 0 0120 0000 beef 1
2 0 0121 0000 0121 1
2 0 0127 0000 0127 1
3 1 0208 a5a5 a5a5 0
3 0 0a08 0000 0a08 0
3 0 0208 0000 a5a5 0
3 0 020f 0000 020f 1
4 0 0011 0000 0011 1
4 0 1231 0000 1231 1
4 0 0124 0000 0124 1
4 0 020a 0000 020a 1
4 0 0120 0000 beef 1
4 0 1235 0000 1235 1
5 1 0122 1111 1111 1
5 0 0122 0000 1111 1
5 1 0922 3333 3333 0
5 0 0122 0000 1111 0
5 0 0922 0000 3333 0
6 1 3456 7777 7777 0
6 2 0000 0000 0000 0
6 0 3456 0000 3456 0
6 0 0208 0000 a5a5 0
6 0 3457 0000 3457 1

/* all.f */
verilog/cache_pkg.sv
verilog/cache_pipe_if.sv
verilog/line_update_if.sv
verilog/cache_lookup.sv
verilog/line_refill.sv
verilog/word_access.sv
verilog/data_cache_top.sv
tests/data_cache_props.sv
tests/data_cache_tb.sv

/* Bender.yml */
package:
  name: data_cache

sources:
  - verilog/cache_pkg.sv
  - verilog/cache_pipe_if.sv
  - verilog/line_update_if.sv
  - verilog/cache_lookup.sv
  - verilog/line_refill.sv
  - verilog/word_access.sv
  - verilog/data_cache_top.sv
  - target: test
    files:
      - tests/data_cache_props.sv
      - tests/data_cache_tb.sv

/* tests/data_cache_tb.sv */
`timescale 1ns/1ps

module data_cache_tb;
	import cache_pkg::*;

	localparam int TIMEOUT = 200;	// cycles allowed per wait

	typedef struct packed {
		logic [15:0] test;
		logic        write;
		word_t       data;
		logic        hit;
	} expect_t;

	logic  clk;
	logic  rst_n;
	logic  req_valid;
	logic  req_write;
	addr_t req_addr;
	word_t req_wdata;
	logic  req_ready;
	logic  rsp_ready;
	logic  rsp_valid;
	logic  rsp_write;
	logic  rsp_hit;
	word_t rsp_rdata;

	expect_t exp_q[$];	// oldest outstanding request first
	integer  seed = 8211;
	int      errors, checks, tests, failed_tests;
	bit      aborted;

	data_cache_top #(
		.MEM_LATENCY (4)
	) u_data_cache_top (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// random response back-pressure with ready about three cycles in four
	initial begin
		rsp_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1 rsp_ready = ($random(seed) & 3) != 0;
		end
	end

	task automatic check_value(input int test, input string name,
			input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] test %0d: %s got 0x%h expected 0x%h", test, name, got, exp);
		end
	endtask

	// sampled at the falling edge before the transfer edge
	always @(negedge clk) begin
		expect_t e;
		if (rst_n && rsp_valid && rsp_ready) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("a response arrived with no request outstanding");
			end else begin
				e = exp_q.pop_front();
				check_value(e.test, "rsp_write", rsp_write, e.write);
				check_value(e.test, "rsp_hit", rsp_hit, e.hit);
				check_value(e.test, "rsp_rdata", rsp_rdata, e.data);
			end
		end
	end

	task automatic reset_dut();
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (exp_q.size() != 0 && !aborted) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) begin
				$display("timed out waiting for %0d outstanding responses", exp_q.size());
				aborted = 1'b1;
			end
		end
		@(posedge clk);
		#1;
	endtask

	task automatic send_request(input int test, input logic write, input addr_t addr,
			input word_t wdata, input word_t exp_data, input logic exp_hit);
		expect_t e;
		int n;
		n = 0;
		req_valid = 1'b1;
		req_write = write;
		req_addr  = addr;
		req_wdata = wdata;
		@(negedge clk);
		while (!req_ready && !aborted) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) begin
				$display("timed out waiting for the cache to accept a request");
				aborted = 1'b1;
			end
		end
		e = {16'(test), write, exp_data, exp_hit};
		if (!aborted)
			exp_q.push_back(e);
		@(posedge clk);
		#1 req_valid = 1'b0;
	endtask

	task automatic end_test(input int test, input int err_before);
		wait_drained();
		tests++;
		if (errors != err_before || aborted) begin
			failed_tests++;
			$display("test %0d failed", test);
		end else begin
			$display("test %0d passed", test);
		end
	endtask

	initial begin : driver
		int fd, n, test, op, hit, cur_test, err_before;
		int assert_fails;
		logic [15:0] addr, wdata, rdata;
		logic [8*96-1:0] text;

		rst_n     = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr  = '0;
		req_wdata = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		aborted = 1'b0;
		cur_test = -1;
		err_before = 0;
		n = 0;
		reset_dut();

		fd = $fopen("tests/data_cache_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file");
			aborted = 1'b1;
		end else begin
			n = $fgets(text, fd);
		end
		while (n > 0 && !aborted) begin
			// comment and blank lines do not scan as six fields
			if ($sscanf(text, "%d %d %h %h %h %d", test, op, addr, wdata, rdata, hit) == 6) begin
				if (test != cur_test) begin
					if (cur_test >= 0)
						end_test(cur_test, err_before);
					cur_test   = test;
					err_before = errors;
				end
				if (op == 2) begin
					wait_drained();
					reset_dut();
				end else begin
					send_request(test, op[0], addr[14:0], wdata, rdata, hit[0]);
				end
			end
			n = $fgets(text, fd);
		end
		if (cur_test >= 0)
			end_test(cur_test, err_before);
		if (fd != 0)
			$fclose(fd);

		assert_fails = u_data_cache_top.u_data_cache_props.fail_count;
		$display("%0d tests run, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			tests, failed_tests, checks, errors, assert_fails);
		if (errors == 0 && failed_tests == 0 && !aborted && tests > 0 && assert_fails == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* tests/data_cache_props.sv */
`timescale 1ns/1ps

module data_cache_props (
	input logic             clk,
	input logic             rst_n,
	input logic             req_valid,
	input logic             req_write,
	input cache_pkg::addr_t req_addr,
	input cache_pkg::word_t req_wdata,
	input logic             req_ready,
	input logic             rsp_ready,
	input logic             rsp_valid,
	input logic             rsp_write,
	input logic             rsp_hit,
	input cache_pkg::word_t rsp_rdata
);

	logic [15:0] kind_fifo;	// request kinds in acceptance order
	logic [3:0]  wr_ptr;
	logic [3:0]  rd_ptr;
	int          fail_count = 0;	// assertion failures so far

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			kind_fifo <= '0;
			wr_ptr    <= '0;
			rd_ptr    <= '0;
		end else begin
			if (req_valid && req_ready) begin
				kind_fifo[wr_ptr] <= req_write;
				wr_ptr            <= wr_ptr + 1'b1;
			end
			if (rsp_valid && rsp_ready)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid && !req_ready |=>
			req_valid && $stable(req_write) && $stable(req_addr) && $stable(req_wdata))
		else begin
			fail_count++;
			$error("request payload changed while stalled");
		end

	rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=>
			rsp_valid && $stable(rsp_write) && $stable(rsp_hit) && $stable(rsp_rdata))
		else begin
			fail_count++;
			$error("response changed while held");
		end

	quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !rsp_valid [*3])
		else begin
			fail_count++;
			$error("response too soon after reset");
		end

	kind_in_order: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && rsp_ready |-> rsp_write == kind_fifo[rd_ptr])
		else begin
			fail_count++;
			$error("response kind out of request order");
		end

endmodule

bind data_cache_top data_cache_props u_data_cache_props (.*);

/* verilog/data_cache_top.sv */
`timescale 1ns/1ps

module data_cache_top #(
	parameter int MEM_LATENCY = 4	// wait cycles per backing memory access
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             req_valid,
	input  logic             req_write,
	input  cache_pkg::addr_t req_addr,
	input  cache_pkg::word_t req_wdata,
	output logic             req_ready,
	input  logic             rsp_ready,
	output logic             rsp_valid,
	output logic             rsp_write,
	output logic             rsp_hit,
	output cache_pkg::word_t rsp_rdata
);

	cache_pipe_if  s1 ();	// lookup to refill
	cache_pipe_if  s2 ();	// refill to word access
	line_update_if upd ();	// finished line back to lookup

	cache_lookup u_cache_lookup (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_ready (req_ready),
		.s1        (s1),
		.upd       (upd)
	);

	line_refill #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_line_refill (
		.clk   (clk),
		.rst_n (rst_n),
		.s1    (s1),
		.s2    (s2)
	);

	word_access u_word_access (
		.clk       (clk),
		.rst_n     (rst_n),
		.rsp_ready (rsp_ready),
		.rsp_valid (rsp_valid),
		.rsp_write (rsp_write),
		.rsp_hit   (rsp_hit),
		.rsp_rdata (rsp_rdata),
		.s2        (s2),
		.upd       (upd)
	);

endmodule

/* verilog/word_access.sv */
`timescale 1ns/1ps

module word_access (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             rsp_ready,
	output logic             rsp_valid,
	output logic             rsp_write,
	output logic             rsp_hit,
	output cache_pkg::word_t rsp_rdata,
	cache_pipe_if.sink       s2,
	line_update_if.source    upd
);
	import cache_pkg::*;

	logic    take;
	offset_t offset;
	line_t   new_line;
	word_t   sel_word;

	// a held response stalls the pipe behind it
	assign s2.ready = !rsp_valid || rsp_ready;
	assign take     = s2.valid && s2.ready;
	assign offset   = addr_offset(s2.addr);

	// merge the store word, then pick the addressed word from the result
	always_comb begin
		new_line = s2.line;
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			if (s2.write && offset == offset_t'(w))
				new_line[w*WORD_W +: WORD_W] = s2.wdata;
		end
		sel_word = new_line[offset*WORD_W +: WORD_W];
	end

	// line goes back to lookup on the same edge the response loads
	assign upd.valid = take;
	assign upd.index = addr_index(s2.addr);
	assign upd.tag   = addr_tag(s2.addr);
	assign upd.line  = new_line;
	assign upd.dirty = s2.write || (s2.hit && s2.victim_dirty);	// read miss leaves it clean

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else if (take)
			rsp_valid <= 1'b1;
		else if (rsp_ready)
			rsp_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			rsp_write <= s2.write;
			rsp_hit   <= s2.hit;
			rsp_rdata <= sel_word;
		end
	end

endmodule

/* verilog/line_refill.sv */
`timescale 1ns/1ps

module line_refill #(
	parameter int MEM_LATENCY = 4
) (
	input  logic         clk,
	input  logic         rst_n,
	cache_pipe_if.sink   s1,
	cache_pipe_if.source s2
);
	import cache_pkg::*;

	localparam int NUM_BLOCKS = 1 << $bits(block_t);
	localparam int CNT_W      = $clog2(MEM_LATENCY + 1);

	typedef enum logic [1:0] {
		IDLE,
		WRITE_BACK,
		FETCH,
		DONE
	} state_t;

	state_t state;
	logic [CNT_W-1:0] cnt;	// wait cycles of the current memory access
	logic out_valid;
	logic take;
	logic wb_last;

	logic  write_q;
	addr_t addr_q;
	word_t wdata_q;
	line_t line_q;
	logic  hit_q;
	logic  victim_dirty_q;
	tag_t  victim_tag_q;

	block_t victim_blk;
	block_t fill_blk;

	line_t mem [NUM_BLOCKS];	// backing memory, one line per block

	// each word starts out as its own word address
	initial begin
		for (int b = 0; b < NUM_BLOCKS; b++) begin
			for (int w = 0; w < WORDS_PER_LINE; w++) begin
				mem[b][w*WORD_W +: WORD_W] = word_t'(b * WORDS_PER_LINE + w);
			end
		end
	end

	assign s1.ready   = (state == IDLE) && (!out_valid || s2.ready);
	assign take       = s1.valid && s1.ready;
	assign wb_last    = (state == WRITE_BACK) && (cnt == CNT_W'(MEM_LATENCY));
	assign victim_blk = {victim_tag_q, addr_index(addr_q)};
	assign fill_blk   = addr_block(addr_q);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			cnt       <= '0;
			out_valid <= 1'b0;
		end else begin
			if (s2.valid && s2.ready)
				out_valid <= 1'b0;

			case (state)
				IDLE: begin
					if (take) begin
						cnt <= '0;
						if (s1.hit)
							out_valid <= 1'b1;	// hit passes straight through
						else
							state <= s1.victim_dirty ? WRITE_BACK : FETCH;
					end
				end
				WRITE_BACK: begin	// wait, then store the victim
					if (wb_last) begin
						state <= FETCH;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				FETCH: begin
					if (cnt == CNT_W'(MEM_LATENCY - 1))
						state <= DONE;
					else
						cnt <= cnt + 1'b1;
				end
				DONE: begin	// read lands in line_q on this edge
					out_valid <= 1'b1;
					state     <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			write_q        <= s1.write;
			addr_q         <= s1.addr;
			wdata_q        <= s1.wdata;
			line_q         <= s1.line;
			hit_q          <= s1.hit;
			victim_dirty_q <= s1.victim_dirty;
			victim_tag_q   <= s1.victim_tag;
		end else if (state == DONE) begin
			line_q <= mem[fill_blk];
		end
	end

	always @(posedge clk) begin
		if (wb_last)
			mem[victim_blk] <= line_q;
	end

	assign s2.valid        = out_valid;
	assign s2.write        = write_q;
	assign s2.addr         = addr_q;
	assign s2.wdata        = wdata_q;
	assign s2.line         = line_q;
	assign s2.hit          = hit_q;
	assign s2.victim_dirty = victim_dirty_q;
	assign s2.victim_tag   = victim_tag_q;

endmodule

/* verilog/cache_lookup.sv */
`timescale 1ns/1ps

module cache_lookup (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             req_valid,
	input  logic             req_write,
	input  cache_pkg::addr_t req_addr,
	input  cache_pkg::word_t req_wdata,
	output logic             req_ready,
	cache_pipe_if.source     s1,
	line_update_if.sink      upd
);
	import cache_pkg::*;

	tag_t  tag_arr [NUM_LINES];
	line_t data_arr [NUM_LINES];
	logic [NUM_LINES-1:0] valid_arr;
	logic [NUM_LINES-1:0] dirty_arr;
	logic [NUM_LINES-1:0] busy;	// index has an item somewhere down the pipe

	index_t req_index;
	tag_t   req_tag;
	logic   take;

	assign req_index = addr_index(req_addr);
	assign req_tag   = addr_tag(req_addr);

	// a busy index waits until its line has been written back from word access
	assign req_ready = (!s1.valid || s1.ready) && !busy[req_index];
	assign take      = req_valid && req_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1.valid  <= 1'b0;
			busy      <= '0;
			valid_arr <= '0;
			dirty_arr <= '0;
			for (int i = 0; i < NUM_LINES; i++) begin
				tag_arr[i] <= '0;
			end
		end else begin
			if (take)
				s1.valid <= 1'b1;
			else if (s1.ready)
				s1.valid <= 1'b0;

			if (upd.valid) begin
				busy[upd.index]      <= 1'b0;
				tag_arr[upd.index]   <= upd.tag;
				valid_arr[upd.index] <= 1'b1;
				dirty_arr[upd.index] <= upd.dirty;
			end

			if (take)
				busy[req_index] <= 1'b1;	// never the index being updated
		end
	end

	// line payload
	always_ff @(posedge clk) begin
		if (upd.valid)
			data_arr[upd.index] <= upd.line;
	end

	// stage register, the lookup result travels with the request
	always_ff @(posedge clk) begin
		if (take) begin
			s1.write        <= req_write;
			s1.addr         <= req_addr;
			s1.wdata        <= req_wdata;
			s1.line         <= data_arr[req_index];
			s1.hit          <= valid_arr[req_index] && (tag_arr[req_index] == req_tag);
			s1.victim_dirty <= dirty_arr[req_index];
			s1.victim_tag   <= tag_arr[req_index];
		end
	end

endmodule

/* verilog/line_update_if.sv */
`timescale 1ns/1ps

// finished line going back into the lookup arrays, always accepted
interface line_update_if;
	import cache_pkg::*;

	logic   valid;
	index_t index;
	tag_t   tag;
	line_t  line;
	logic   dirty;

	modport source (
		output valid, index, tag, line, dirty
	);

	modport sink (
		input  valid, index, tag, line, dirty
	);

endinterface

/* verilog/cache_pipe_if.sv */
`timescale 1ns/1ps

interface cache_pipe_if;
	import cache_pkg::*;

	logic  valid;
	logic  ready;
	logic  write;		// 1 for a store, 0 for a load
	addr_t addr;
	word_t wdata;
	line_t line;		// cached line on a hit, refilled line after a miss
	logic  hit;
	logic  victim_dirty;	// line at the index was dirty at lookup
	tag_t  victim_tag;

	modport source (
		output valid, write, addr, wdata, line, hit, victim_dirty, victim_tag,
		input  ready
	);

	modport sink (
		input  valid, write, addr, wdata, line, hit, victim_dirty, victim_tag,
		output ready
	);

endinterface

/* verilog/cache_pkg.sv */
package cache_pkg;

	localparam int WORD_W   = 16;
	localparam int TAG_W    = 4;
	localparam int INDEX_W  = 8;
	localparam int OFFSET_W = 3;
	localparam int ADDR_W   = TAG_W + INDEX_W + OFFSET_W;	// 15-bit word address

	localparam int NUM_LINES      = 1 << INDEX_W;	// 256 lines
	localparam int WORDS_PER_LINE = 1 << OFFSET_W;	// 8 words per line

	typedef logic [WORD_W-1:0]                  word_t;
	typedef logic [ADDR_W-1:0]                  addr_t;
	typedef logic [TAG_W-1:0]                   tag_t;
	typedef logic [INDEX_W-1:0]                 index_t;
	typedef logic [OFFSET_W-1:0]                offset_t;
	typedef logic [TAG_W+INDEX_W-1:0]           block_t;	// tag then index
	typedef logic [WORDS_PER_LINE*WORD_W-1:0]   line_t;	// word 0 in the low bits

	// address field helpers
	function automatic tag_t addr_tag(addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[OFFSET_W +: INDEX_W];
	endfunction

	function automatic offset_t addr_offset(addr_t a);
		return a[OFFSET_W-1:0];
	endfunction

	function automatic block_t addr_block(addr_t a);
		return a[ADDR_W-1 -: TAG_W+INDEX_W];
	endfunction

endpackage
